/* mult_unit.f */
logic/mult_op_pkg.sv
logic/mult_lane_pkg.sv
logic/mult_operand_split.sv
logic/mult_lane.sv
logic/mult_result_merge.sv
logic/mult_mulh_seq.sv
logic/mult_unit.sv
verif/tb_mult_unit.sv

/* Bender.yml */
package:
  name: mult_unit

sources:
  - logic/mult_op_pkg.sv
  - logic/mult_lane_pkg.sv
  - logic/mult_operand_split.sv
  - logic/mult_lane.sv
  - logic/mult_result_merge.sv
  - logic/mult_mulh_seq.sv
  - logic/mult_unit.sv
  - target: test
    files:
      - verif/tb_mult_unit.sv

/* verif/tb_mult_unit.sv */
`timescale 1ns/1ps

module tb_mult_unit
	import mult_op_pkg::*;
	import mult_lane_pkg::*;
();

	localparam int N_MAC     = 64;
	localparam int N_SHORT   = 128;
	localparam int N_DOT     = 64;
	localparam int N_MULH    = 32;
	localparam int N_STALL   = 8;
	localparam int MAX_STALL = 16;
	localparam int LIMIT_NS  = ((N_MAC + N_SHORT + N_DOT + N_MULH + N_STALL) * 4
		+ N_STALL * MAX_STALL + 100) * 8;

	logic            clk, rst_n, enable_i, short_subword_i, ex_ready_i;
	logic            multicycle_o, ready_o;
	logic [OP_W-1:0] operator_i;
	logic [1:0]      short_signed_i, dot_signed_i;
	logic [31:0]     op_a_i, op_b_i, op_c_i, result_o;
	logic [4:0]      imm_i;
	logic            chk_en, chk_res, exp_ready, exp_mc;
	mult_word_u      exp_res;
	logic [31:0]     lfsr_state;

	mult_unit u_mult_unit (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1.
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Low field of v, read as signed when sgn is set.
	function automatic logic signed [63:0] extend_field(input logic [31:0] v, input int bits,
		input logic sgn);
		logic [63:0] field;
		field = {32'h0, v} & ((64'd1 << bits) - 64'd1);
		if (sgn && v[bits-1])
			field = field - (64'd1 << bits);
		return field;
	endfunction

	function automatic logic [31:0] model_mult(input logic [OP_W-1:0] op, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] c, input logic sub, input logic [1:0] ssign,
		input logic [1:0] dsign, input logic [4:0] imm);
		logic signed [63:0] x, y;
		logic [63:0]        acc;
		logic [31:0]        word;
		acc  = '0;
		word = '0;
		case (op)
			MUL_MAC32: word = c + a * b;
			MUL_MSU32: word = c - a * b;
			MUL_I, MUL_IR: begin
				x   = extend_field(a >> (16 * sub), 16, ssign[0]);
				y   = extend_field(b >> (16 * sub), 16, ssign[1]);
				acc = x * y + c;
				if (op == MUL_IR && imm != 0)
					acc = acc + (64'd1 << (imm - 1)); // Half an LSB of the shifted result.
				if (ssign[0])
					word = $signed(acc[31:0]) >>> imm;
				else
					word = acc[31:0] >> imm;
			end
			MUL_DOT8: begin
				for (int i = 0; i < 4; i++)
					acc = acc + extend_field(a >> (8 * i), 8, dsign[1])
						* extend_field(b >> (8 * i), 8, dsign[0]);
				word = acc[31:0] + c;
			end
			MUL_DOT16: begin
				for (int i = 0; i < 2; i++)
					acc = acc + extend_field(a >> (16 * i), 16, dsign[1])
						* extend_field(b >> (16 * i), 16, dsign[0]);
				word = acc[31:0] + c;
			end
			MUL_H: begin
				x    = extend_field(a, 32, ssign[0]);
				y    = extend_field(b, 32, ssign[1]);
				acc  = x * y;
				word = acc[63:32];
			end
			default: word = '0;
		endcase
		return word;
	endfunction

	task automatic compare_result(input mult_word_u got, input mult_word_u want);
		if (got !== want) begin
			$display("mismatch result_o: got %h expected %h (operator %0d)", got, want, operator_i);
			$display("TEST FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic compare_flags(input logic rdy, input logic mc, input logic rdy_exp,
		input logic mc_exp);
		if (rdy !== rdy_exp || mc !== mc_exp) begin
			$display("mismatch ready_o/multicycle_o: got %h/%h expected %h/%h",
				rdy, mc, rdy_exp, mc_exp);
			$display("TEST FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic want_flags(input logic rdy, input logic mc);
		chk_en    <= 1'b1;
		chk_res   <= 1'b0;
		exp_ready <= rdy;
		exp_mc    <= mc;
	endtask

	task automatic want_result(input mult_word_u w);
		want_flags(1'b1, 1'b0);
		chk_res <= 1'b1;
		exp_res <= w;
	endtask

	task automatic run_single(input logic [OP_W-1:0] op, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] c, input logic sub, input logic [1:0] ssign,
		input logic [1:0] dsign, input logic [4:0] imm);
		@(posedge clk);
		operator_i      <= op;
		op_a_i          <= a;
		op_b_i          <= b;
		op_c_i          <= c;
		short_subword_i <= sub;
		short_signed_i  <= ssign;
		dot_signed_i    <= dsign;
		imm_i           <= imm;
		enable_i        <= 1'b1;
		want_result(model_mult(op, a, b, c, sub, ssign, dsign, imm));
	endtask

	// A following MUL_H shows the unit went back to idle after ex_ready_i rose.
	task automatic run_mulh(input logic [31:0] a, input logic [31:0] b, input logic [1:0] ssign,
		input int stall);
		mult_word_u upper;
		upper = model_mult(MUL_H, a, b, 32'h0, 1'b0, ssign, 2'b00, 5'd0);
		@(posedge clk);
		operator_i     <= MUL_H;
		op_a_i         <= a;
		op_b_i         <= b;
		short_signed_i <= ssign;
		enable_i       <= 1'b1;
		ex_ready_i     <= (stall == 0);
		want_flags(1'b0, 1'b0);
		@(posedge clk);
		enable_i <= 1'b0;
		want_flags(1'b0, 1'b1); // Low pass.
		for (int k = 0; k < stall; k++) begin
			@(posedge clk);
			want_result(upper); // Held under back-pressure.
		end
		@(posedge clk);
		ex_ready_i <= 1'b1;
		want_result(upper);
	endtask

	always @(negedge clk) begin
		if (chk_en) begin
			compare_flags(ready_o, multicycle_o, exp_ready, exp_mc);
			if (chk_res)
				compare_result(result_o, exp_res);
		end
	end

	initial begin
		#(LIMIT_NS);
		$display("timeout: the run hung before the last vector completed");
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rst_n           = 1'b0;
		enable_i        = 1'b0;
		operator_i      = MUL_MAC32;
		short_subword_i = 1'b0;
		short_signed_i  = 2'b00;
		dot_signed_i    = 2'b00;
		op_a_i          = '0;
		op_b_i          = '0;
		op_c_i          = '0;
		imm_i           = '0;
		ex_ready_i      = 1'b1;
		chk_en          = 1'b0;
		chk_res         = 1'b0;
		exp_ready       = 1'b1;
		exp_mc          = 1'b0;
		exp_res         = '0;
		lfsr_state      = 32'hfef11d69;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		want_flags(1'b1, 1'b0);
		for (int i = 0; i < N_MAC; i++)
			run_single(i[0] ? MUL_MSU32 : MUL_MAC32, take_bits(32), take_bits(32),
				take_bits(32), 1'b0, 2'b00, 2'b00, 5'd0);
		for (int i = 0; i < N_SHORT; i++)
			run_single(i[0] ? MUL_IR : MUL_I, take_bits(32), take_bits(32), take_bits(32),
				i[6], take_bits(2), 2'b00, i[5:1]);
		for (int i = 0; i < N_DOT; i++)
			run_single(i[0] ? MUL_DOT16 : MUL_DOT8, take_bits(32), take_bits(32),
				take_bits(32), 1'b0, 2'b00, i[2:1], 5'd0);
		for (int i = 0; i < N_MULH; i++)
			run_mulh(take_bits(32), take_bits(32), i[1:0], 0);
		for (int i = 0; i < N_STALL; i++)
			run_mulh(take_bits(32), take_bits(32), i[1:0], 1 + int'(take_bits(4)));
		@(posedge clk);
		enable_i <= 1'b0;
		want_flags(1'b1, 1'b0);
		@(posedge clk);
		chk_en <= 1'b0;
		$display("TEST PASS");
		$finish;
	end

endmodule

/* logic/mult_unit.sv */
`timescale 1ns/1ps

module mult_unit
	import mult_op_pkg::*;
	import mult_lane_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            enable_i,
	input  logic [OP_W-1:0] operator_i,
	input  logic            short_subword_i,
	input  logic [1:0]      short_signed_i,
	input  logic [31:0]     op_a_i,
	input  logic [31:0]     op_b_i,
	input  logic [31:0]     op_c_i,
	input  logic [4:0]      imm_i,
	input  logic [1:0]      dot_signed_i,
	input  logic            ex_ready_i,
	output logic [31:0]     result_o,
	output logic            multicycle_o,
	output logic            ready_o
);

	logic [LANE_COUNT-1:0][15:0]          lane_a;
	logic [LANE_COUNT-1:0][15:0]          lane_b;
	logic [LANE_COUNT-1:0]                lane_sign_a;
	logic [LANE_COUNT-1:0]                lane_sign_b;
	logic                                 lane_byte;
	logic                                 lane_neg;
	logic [LANE_COUNT-1:0][LANE_PROD_W-1:0] lane_prod;
	logic [1:0]                           pass;
	logic [LANE_PROD_W-1:0]               saved_low;
	logic [LANE_PROD_W-1:0]               saved_q;

	mult_operand_split u_split (
		.operator_i      (operator_i),
		.pass_i          (pass),
		.op_a_i          (op_a_i),
		.op_b_i          (op_b_i),
		.short_subword_i (short_subword_i),
		.short_signed_i  (short_signed_i),
		.dot_signed_i    (dot_signed_i),
		.lane_a_o        (lane_a),
		.lane_b_o        (lane_b),
		.lane_sign_a_o   (lane_sign_a),
		.lane_sign_b_o   (lane_sign_b),
		.lane_byte_o     (lane_byte),
		.lane_neg_o      (lane_neg)
	);

	for (genvar g = 0; g < LANE_COUNT; g++) begin : g_lane
		mult_lane u_lane (
			.a_i      (lane_a[g]),
			.b_i      (lane_b[g]),
			.sign_a_i (lane_sign_a[g]),
			.sign_b_i (lane_sign_b[g]),
			.byte_i   (lane_byte),
			.neg_i    (lane_neg),
			.prod_o   (lane_prod[g])
		);
	end

	mult_result_merge u_merge (
		.operator_i     (operator_i),
		.pass_i         (pass),
		.lane_prod_i    (lane_prod),
		.op_c_i         (op_c_i),
		.imm_i          (imm_i),
		.short_signed_i (short_signed_i),
		.saved_i        (saved_q),
		.saved_o        (saved_low),
		.result_o       (result_o)
	);

	mult_mulh_seq u_seq (
		.clk          (clk),
		.rst_n        (rst_n),
		.enable_i     (enable_i),
		.operator_i   (operator_i),
		.ex_ready_i   (ex_ready_i),
		.saved_i      (saved_low),
		.saved_o      (saved_q),
		.pass_o       (pass),
		.multicycle_o (multicycle_o),
		.ready_o      (ready_o)
	);

endmodule

/* logic/mult_mulh_seq.sv */
`timescale 1ns/1ps

module mult_mulh_seq
	import mult_op_pkg::*;
	import mult_lane_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   enable_i,
	input  logic [OP_W-1:0]        operator_i,
	input  logic                   ex_ready_i,
	input  logic [LANE_PROD_W-1:0] saved_i,
	output logic [LANE_PROD_W-1:0] saved_o,
	output logic [1:0]             pass_o,
	output logic                   multicycle_o,
	output logic                   ready_o
);

	// States are encoded as the pass they drive.
	localparam logic [1:0] ST_IDLE = PASS_NONE;
	localparam logic [1:0] ST_LOW  = PASS_LOW;
	localparam logic [1:0] ST_HIGH = PASS_HIGH;

	logic [1:0]             state_q;
	logic [1:0]             state_d;
	logic [LANE_PROD_W-1:0] saved_q;

	always_comb begin
		state_d      = state_q;
		multicycle_o = 1'b0;
		ready_o      = 1'b0;
		case (state_q)
			ST_IDLE: begin
				ready_o = 1'b1;
				if (enable_i && operator_i == MUL_H) begin
					ready_o = 1'b0;
					state_d = ST_LOW;
				end
			end
			ST_LOW: begin
				multicycle_o = 1'b1;
				state_d      = ST_HIGH;
			end
			ST_HIGH: begin
				ready_o = 1'b1;
				if (ex_ready_i)
					state_d = ST_IDLE; // Result taken downstream.
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			saved_q <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == ST_LOW)
				saved_q <= saved_i;
			else if (state_q == ST_HIGH && ex_ready_i)
				saved_q <= '0;
		end
	end

	assign saved_o = saved_q;
	assign pass_o  = state_q;

	a_hold_high: assert property (@(posedge clk) disable iff (!rst_n)
		(state_q == ST_HIGH && !ex_ready_i) |=> state_q == ST_HIGH)
		else $error("MUL_H result dropped under back-pressure");

	a_ready_mc: assert property (@(posedge clk) disable iff (!rst_n)
		!(ready_o && multicycle_o))
		else $error("ready_o and multicycle_o both high");

endmodule

/* logic/mult_result_merge.sv */
`timescale 1ns/1ps

module mult_result_merge
	import mult_op_pkg::*;
	import mult_lane_pkg::*;
(
	input  logic [OP_W-1:0]                        operator_i,
	input  logic [1:0]                             pass_i,
	input  logic [LANE_COUNT-1:0][LANE_PROD_W-1:0] lane_prod_i,
	input  mult_word_u                             op_c_i,
	input  logic [4:0]                             imm_i,
	input  logic [1:0]                             short_signed_i,
	input  logic [LANE_PROD_W-1:0]                 saved_i,
	output logic [LANE_PROD_W-1:0]                 saved_o,
	output mult_word_u                             result_o
);

	logic signed [LANE_PROD_W-1:0] p0;
	logic signed [LANE_PROD_W-1:0] p1;
	logic signed [LANE_PROD_W-1:0] p2;
	logic signed [LANE_PROD_W-1:0] p3;
	logic signed [LANE_PROD_W-1:0] p1_hi;
	logic signed [LANE_PROD_W-1:0] p2_hi;
	logic signed [LANE_PROD_W-1:0] acc;
	logic [LANE_PROD_W-1:0]        round;
	logic [LANE_PROD_W-1:0]        dot_sum;
	logic [LANE_PROD_W-1:0]        mac_sum;
	logic [LANE_PROD_W-1:0]        short_sum;
	logic [LANE_PROD_W-1:0]        low_sum;
	logic [LANE_PROD_W-1:0]        high_sum;
	logic signed [32:0]            shift_in;
	logic [32:0]                   short_res;

	assign p0  = lane_prod_i[0];
	assign p1  = lane_prod_i[1];
	assign p2  = lane_prod_i[2];
	assign p3  = lane_prod_i[3];
	assign acc = {{(LANE_PROD_W-32){op_c_i.halves[1][15]}}, op_c_i};

	// Unused lanes carry zero, so one sum covers both dot products.
	assign dot_sum = p0 + p1 + p2 + p3 + acc;
	assign mac_sum = p0 + ((p1 + p2) <<< 16) + acc;

	// Half an LSB of the shifted result, zero when imm_i is zero.
	assign round = (operator_i == MUL_IR) ? ((LANE_PROD_W'(1) << imm_i) >> 1) : '0;

	assign short_sum = p0 + acc + round;
	assign shift_in  = {short_signed_i[0] & short_sum[31], short_sum[31:0]};
	assign short_res = shift_in >>> imm_i;

	// Low pass keeps the cross product bits that fall below bit 32.
	assign low_sum = p0
		+ {{(LANE_PROD_W-32){1'b0}}, p1[15:0], 16'h0000}
		+ {{(LANE_PROD_W-32){1'b0}}, p2[15:0], 16'h0000};

	assign p1_hi    = p1 >>> 16;
	assign p2_hi    = p2 >>> 16;
	assign high_sum = p3 + p1_hi + p2_hi + saved_i; // Carries from the low pass.

	assign saved_o = (pass_i == PASS_LOW) ? {32'h0000_0000, low_sum[LANE_PROD_W-1:32]} : '0;

	always_comb begin
		case (operator_i)
			MUL_MAC32, MUL_MSU32: result_o = mac_sum[31:0];
			MUL_I, MUL_IR:        result_o = short_res[31:0];
			MUL_DOT8, MUL_DOT16:  result_o = dot_sum[31:0];
			MUL_H:                result_o = (pass_i == PASS_HIGH) ? high_sum[31:0]
			                                                       : low_sum[31:0];
			default:              result_o = '0;
		endcase
	end

	// The sequencer only leaves idle for MUL_H, and the operator is held meanwhile.
	a_pass_mulh: assert final (pass_i == PASS_NONE || operator_i === MUL_H)
		else $error("MUL_H pass active for operator %0d", operator_i);

endmodule

/* logic/mult_lane.sv */
`timescale 1ns/1ps

module mult_lane
	import mult_lane_pkg::*;
(
	input  logic [15:0]            a_i,
	input  logic [15:0]            b_i,
	input  logic                   sign_a_i,
	input  logic                   sign_b_i,
	input  logic                   byte_i,
	input  logic                   neg_i,
	output logic [LANE_PROD_W-1:0] prod_o
);

	logic signed [LANE_OP_W-1:0]   a_ext;
	logic signed [LANE_OP_W-1:0]   b_ext;
	logic signed [LANE_PROD_W-1:0] prod;

	// In byte mode only the low byte counts and bit 7 is the sign.
	assign a_ext = byte_i ? {{(LANE_OP_W-8){sign_a_i & a_i[7]}}, a_i[7:0]}
	                      : {sign_a_i & a_i[15], a_i};
	assign b_ext = byte_i ? {{(LANE_OP_W-8){sign_b_i & b_i[7]}}, b_i[7:0]}
	                      : {sign_b_i & b_i[15], b_i};

	assign prod   = a_ext * b_ext;
	assign prod_o = neg_i ? -prod : prod; // MSU32 subtracts every partial.

	// Negation is only meant for MSU32, which never runs in byte mode.
	a_byte_neg: assert final (!(byte_i === 1'b1 && neg_i === 1'b1))
		else $error("lane in byte mode asked to negate");

endmodule

/* logic/mult_operand_split.sv */
`timescale 1ns/1ps

module mult_operand_split
	import mult_op_pkg::*;
	import mult_lane_pkg::*;
(
	input  logic [OP_W-1:0]              operator_i,
	input  logic [1:0]                   pass_i,
	input  mult_word_u                   op_a_i,
	input  mult_word_u                   op_b_i,
	input  logic                         short_subword_i,
	input  logic [1:0]                   short_signed_i,
	input  logic [1:0]                   dot_signed_i,
	output logic [LANE_COUNT-1:0][15:0]  lane_a_o,
	output logic [LANE_COUNT-1:0][15:0]  lane_b_o,
	output logic [LANE_COUNT-1:0]        lane_sign_a_o,
	output logic [LANE_COUNT-1:0]        lane_sign_b_o,
	output logic                         lane_byte_o,
	output logic                         lane_neg_o
);

	always_comb begin
		lane_a_o      = '0;
		lane_b_o      = '0;
		lane_sign_a_o = '0;
		lane_sign_b_o = '0;
		lane_byte_o   = 1'b0;
		lane_neg_o    = 1'b0;
		case (operator_i)
			MUL_DOT8: begin
				lane_byte_o = 1'b1;
				for (int i = 0; i < LANE_COUNT; i++) begin
					lane_a_o[i]      = {8'h00, op_a_i.bytes[i]};
					lane_b_o[i]      = {8'h00, op_b_i.bytes[i]};
					lane_sign_a_o[i] = dot_signed_i[1];
					lane_sign_b_o[i] = dot_signed_i[0];
				end
			end
			MUL_DOT16: begin
				for (int i = 0; i < 2; i++) begin
					lane_a_o[i]      = op_a_i.halves[i];
					lane_b_o[i]      = op_b_i.halves[i];
					lane_sign_a_o[i] = dot_signed_i[1];
					lane_sign_b_o[i] = dot_signed_i[0];
				end
			end
			MUL_I, MUL_IR: begin
				lane_a_o[0]      = op_a_i.halves[short_subword_i];
				lane_b_o[0]      = op_b_i.halves[short_subword_i];
				lane_sign_a_o[0] = short_signed_i[0];
				lane_sign_b_o[0] = short_signed_i[1];
			end
			MUL_MAC32, MUL_MSU32: begin
				// The high-by-high term lands above bit 31 and is dropped.
				lane_neg_o  = (operator_i == MUL_MSU32);
				lane_a_o[0] = op_a_i.halves[0];
				lane_b_o[0] = op_b_i.halves[0];
				lane_a_o[1] = op_a_i.halves[1];
				lane_b_o[1] = op_b_i.halves[0];
				lane_a_o[2] = op_a_i.halves[0];
				lane_b_o[2] = op_b_i.halves[1];
			end
			MUL_H: begin
				if (pass_i != PASS_NONE) begin
					// Cross products are needed in both passes.
					lane_a_o[1]      = op_a_i.halves[1];
					lane_b_o[1]      = op_b_i.halves[0];
					lane_sign_a_o[1] = short_signed_i[0];
					lane_a_o[2]      = op_a_i.halves[0];
					lane_b_o[2]      = op_b_i.halves[1];
					lane_sign_b_o[2] = short_signed_i[1];
				end
				if (pass_i == PASS_LOW) begin
					lane_a_o[0] = op_a_i.halves[0];
					lane_b_o[0] = op_b_i.halves[0];
				end
				if (pass_i == PASS_HIGH) begin
					lane_a_o[3]      = op_a_i.halves[1];
					lane_b_o[3]      = op_b_i.halves[1];
					lane_sign_a_o[3] = short_signed_i[0];
					lane_sign_b_o[3] = short_signed_i[1];
				end
			end
			default: ;
		endcase
	end

endmodule

/* logic/mult_lane_pkg.sv */
package mult_lane_pkg;

	localparam int LANE_COUNT  = 4;
	localparam int LANE_OP_W   = 17; // 16 data bits and a sign bit.
	localparam int LANE_PROD_W = 2 * LANE_OP_W;

	// A 32-bit operand word. DOT8 reads it as four bytes, everything
	// else as two halfwords.
	typedef union packed {
		logic [3:0][7:0]  bytes;
		logic [1:0][15:0] halves;
	} mult_word_u;

endpackage

/* logic/mult_op_pkg.sv */
package mult_op_pkg;

	localparam int OP_W = 3;

	// Operator codes seen on operator_i.
	localparam logic [OP_W-1:0] MUL_MAC32 = 3'b000;
	localparam logic [OP_W-1:0] MUL_MSU32 = 3'b001;
	localparam logic [OP_W-1:0] MUL_I     = 3'b010;
	localparam logic [OP_W-1:0] MUL_IR    = 3'b011;
	localparam logic [OP_W-1:0] MUL_DOT8  = 3'b100;
	localparam logic [OP_W-1:0] MUL_DOT16 = 3'b101;
	localparam logic [OP_W-1:0] MUL_H     = 3'b110;

	// Which half of a MUL_H the lanes are working on.
	localparam logic [1:0] PASS_NONE = 2'd0;
	localparam logic [1:0] PASS_LOW  = 2'd1; // Low partial plus carries.
	localparam logic [1:0] PASS_HIGH = 2'd2; // Upper product word.

endpackage
